// File: Bender.yml
package:
  name: fifo_centre

sources:
  - files:
      - design/fbc_pkg.sv
      - design/wb_pkg.sv
      - design/fifo_wb_writer.sv
      - design/fifo_dc_16to8.sv
      - design/fifo_wb_reader.sv
      - design/fifo_centre.sv
  - target: test
    files:
      - verif/fifo_centre_tb.sv

// File: design/fbc_pkg.sv
// Channel and data types shared by the frame buffer FIFO path.
// Imported by the FIFO, both Wishbone ports and the testbench.
package fbc_pkg;

	// eight data streams and the attribute stream.
	typedef enum logic [3:0] {
		DS0 = 4'd0, DS1 = 4'd1, DS2 = 4'd2, DS3 = 4'd3,
		DS4 = 4'd4, DS5 = 4'd5, DS6 = 4'd6, DS7 = 4'd7,
		AT  = 4'd8
	} chan_e;

	localparam int NUM_CHAN = 9;

	typedef logic [15:0] word_t; // written word.
	typedef logic [7:0]  byte_t; // read byte.

	typedef struct packed {
		logic        full;
		logic        empty;
		logic [15:0] rd_count; // bytes waiting, zero-extended.
	} chan_status_t;

	// status as it sits on the 16-bit read bus: flags on top, count below.
	function automatic word_t status_word(chan_status_t s);
		return {s.full, s.empty, s.rd_count[13:0]};
	endfunction

	function automatic chan_status_t status_from_word(word_t w);
		return '{full: w[15], empty: w[14], rd_count: {2'b00, w[13:0]}};
	endfunction

endpackage

// File: design/fifo_centre.sv
`timescale 1ns/1ps
// FIFO bank of the frame buffer controller.
// Words written over the write port land in one of nine channel FIFOs,
// bytes and status come back over the read port in the read_clock domain.
module fifo_centre
	import fbc_pkg::*, wb_pkg::*;
#(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic    write_clock,
	input  logic    read_clock,
	input  logic    arst_n,
	input  wb_req_t wr_req,
	output wb_rsp_t wr_rsp,
	input  wb_req_t rd_req,
	output wb_rsp_t rd_rsp
);
	logic [NUM_CHAN-1:0]   wr_en, rd_en;
	logic [NUM_CHAN-1:0]   full, empty;
	word_t                 wr_data;
	byte_t                 dout [NUM_CHAN];
	logic [DEPTH_LOG2+1:0] rd_count [NUM_CHAN];

	fifo_wb_writer writer_i (
		.write_clock (write_clock),
		.arst_n      (arst_n),
		.req         (wr_req),
		.rsp         (wr_rsp),
		.full        (full),
		.wr_en       (wr_en),
		.wr_data     (wr_data)
	);

	for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
		localparam chan_e CH = chan_e'(i);

		fifo_dc_16to8 #(.DEPTH_LOG2(DEPTH_LOG2)) fifo_i (
			.write_clock (write_clock),
			.read_clock  (read_clock),
			.arst_n      (arst_n),
			.wr_en       (wr_en[CH]),
			.din         (wr_data), // one shared word, wr_en picks the channel.
			.rd_en       (rd_en[CH]),
			.dout        (dout[CH]),
			.full        (full[CH]),
			.empty       (empty[CH]),
			.wr_count    (),
			.rd_count    (rd_count[CH])
		);
	end

	fifo_wb_reader #(.DEPTH_LOG2(DEPTH_LOG2)) reader_i (
		.read_clock (read_clock),
		.arst_n     (arst_n),
		.req        (rd_req),
		.rsp        (rd_rsp),
		.dout       (dout),
		.empty      (empty),
		.full       (full),
		.rd_count   (rd_count),
		.rd_en      (rd_en)
	);

endmodule

// File: design/fifo_dc_16to8.sv
`timescale 1ns/1ps
// Dual-clock FIFO, 16-bit words in on write_clock, bytes out on read_clock.
// The high byte of each word comes out first. dout shows the next byte
// before it is popped. Depth is 2**DEPTH_LOG2 words.
module fifo_dc_16to8
	import fbc_pkg::*;
#(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                  write_clock,
	input  logic                  read_clock,
	input  logic                  arst_n,
	input  logic                  wr_en,
	input  word_t                 din,
	input  logic                  rd_en,
	output byte_t                 dout,
	output logic                  full,
	output logic                  empty,
	output logic [DEPTH_LOG2:0]   wr_count,
	output logic [DEPTH_LOG2+1:0] rd_count
);
	localparam int AW = DEPTH_LOG2;

	word_t       mem [2**AW];
	logic [AW:0]   wbin, wbin_next, wgray;
	logic [AW:0]   rq1, rq2, rword_sync;
	logic [AW+1:0] rbin, rbin_next;
	logic [AW:0]   rword_next, rgray;
	logic [AW:0]   wq1, wq2, wbin_sync;
	logic          push, pop;
	word_t         rd_word;

	function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
		logic [AW:0] b;
		b[AW] = g[AW];
		for (int i = AW - 1; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	// write side, word pointer with one extra wrap bit.
	assign push      = wr_en && !full;
	assign wbin_next = wbin + (AW+1)'(push);

	always_ff @(posedge write_clock or negedge arst_n) begin
		if (!arst_n) begin
			wbin  <= '0;
			wgray <= '0;
			rq1   <= '0;
			rq2   <= '0;
		end else begin
			wbin  <= wbin_next;
			wgray <= wbin_next ^ (wbin_next >> 1);
			rq1   <= rgray; // read pointer into write domain.
			rq2   <= rq1;
		end
	end

	always_ff @(posedge write_clock) begin
		if (push) mem[wbin[AW-1:0]] <= din;
	end

	assign rword_sync = gray2bin(rq2);
	assign wr_count   = wbin - rword_sync;
	assign full       = wr_count[AW]; // count reached the full depth.

	// read side counts bytes, bit 0 picks the half of the word.
	assign pop        = rd_en && !empty;
	assign rbin_next  = rbin + (AW+2)'(pop);
	assign rword_next = rbin_next[AW+1:1];

	always_ff @(posedge read_clock or negedge arst_n) begin
		if (!arst_n) begin
			rbin  <= '0;
			rgray <= '0;
			wq1   <= '0;
			wq2   <= '0;
		end else begin
			rbin  <= rbin_next;
			rgray <= rword_next ^ (rword_next >> 1);
			wq1   <= wgray;
			wq2   <= wq1;
		end
	end

	assign wbin_sync = gray2bin(wq2);
	assign empty     = (wbin_sync == rbin[AW+1:1]);
	assign rd_count  = {wbin_sync - rbin[AW+1:1], 1'b0} - (AW+2)'(rbin[0]);

	assign rd_word = mem[rbin[AW:1]];
	assign dout    = rbin[0] ? rd_word[7:0] : rd_word[15:8]; // high byte first.

	a_no_overflow: assert property (@(posedge write_clock) disable iff (!arst_n)
		!(wr_en && full));

	a_no_underflow: assert property (@(posedge read_clock) disable iff (!arst_n)
		!(rd_en && empty));

endmodule

// File: design/fifo_wb_reader.sv
`timescale 1ns/1ps
// Wishbone classic read port on read_clock.
// adr[4] low pops one byte from the addressed channel, high returns its status.
// Every access is answered one cycle after stb, empty data reads with err.
module fifo_wb_reader
	import fbc_pkg::*, wb_pkg::*;
#(
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                  read_clock,
	input  logic                  arst_n,
	input  wb_req_t               req,
	output wb_rsp_t               rsp,
	input  byte_t                 dout [NUM_CHAN],
	input  logic [NUM_CHAN-1:0]   empty,
	input  logic [NUM_CHAN-1:0]   full,
	input  logic [DEPTH_LOG2+1:0] rd_count [NUM_CHAN],
	output logic [NUM_CHAN-1:0]   rd_en
);
	logic         ack_q, err_q;
	word_t        dat_q;
	logic         start, valid;
	logic [3:0]   chan;
	rd_space_e    space;
	chan_status_t status;

	assign start = req.cyc && req.stb && !ack_q && !err_q;
	assign valid = (req.adr[3:0] <= 4'(AT)) && !req.we;
	assign chan  = valid ? req.adr[3:0] : 4'd0;
	assign space = rd_space_e'(req.adr[4]);
	assign rsp   = '{ack: ack_q, err: err_q, dat: dat_q};

	assign status = '{
		full:     full[chan],
		empty:    empty[chan],
		rd_count: 16'(rd_count[chan])
	};

	always_ff @(posedge read_clock or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
			rd_en <= '0;
		end else begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
			rd_en <= '0;
			if (start) begin
				if (!valid || (space == RD_DATA && empty[chan])) begin
					err_q <= 1'b1; // nothing popped.
				end else begin
					ack_q <= 1'b1;
					if (space == RD_DATA) rd_en[chan] <= 1'b1; // pop lands with ack.
				end
			end
		end
	end

	always_ff @(posedge read_clock) begin
		if (start) dat_q <= (space == RD_DATA) ? word_t'(dout[chan]) : status_word(status);
	end

	// a pop only answers a data-space request seen on the edge before.
	a_single_pop: assert property (@(posedge read_clock) disable iff (!arst_n)
		(|rd_en) |-> ($onehot(rd_en) && rsp.ack &&
			$past(req.cyc && req.stb && req.adr[4] == RD_DATA)));

endmodule

// File: design/fifo_wb_writer.sv
`timescale 1ns/1ps
// Wishbone classic write port on write_clock.
// Decodes the channel from adr and pushes dat into that FIFO.
// A write to a full channel waits in HOLD until space frees.
module fifo_wb_writer
	import fbc_pkg::*, wb_pkg::*;
(
	input  logic                write_clock,
	input  logic                arst_n,
	input  wb_req_t             req,
	output wb_rsp_t             rsp,
	input  logic [NUM_CHAN-1:0] full,
	output logic [NUM_CHAN-1:0] wr_en,
	output word_t               wr_data
);
	wr_state_e  state;
	logic       ack_q, err_q;
	logic       start, valid;
	logic [3:0] chan;

	// new cycle only once the previous answer has gone.
	assign start = req.cyc && req.stb && !ack_q && !err_q;
	assign valid = req.adr[3:0] <= 4'(AT);
	assign chan  = valid ? req.adr[3:0] : 4'd0;
	assign rsp   = '{ack: ack_q, err: err_q, dat: '0};

	always_ff @(posedge write_clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			ack_q <= 1'b0;
			err_q <= 1'b0;
			wr_en <= '0;
		end else begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
			wr_en <= '0;
			case (state)
				IDLE: if (start) begin
					if (!valid || !req.we) begin
						err_q <= 1'b1;
					end else if (full[chan]) begin
						state <= HOLD; // back-pressure.
					end else begin
						wr_en[chan] <= 1'b1;
						ack_q       <= 1'b1;
					end
				end
				HOLD: if (!full[chan]) begin
					wr_en[chan] <= 1'b1;
					ack_q       <= 1'b1;
					state       <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge write_clock) begin
		if (start || state == HOLD) wr_data <= req.dat;
	end

	// the answer is registered, so the request stood on the edge before it.
	a_wr_rsp: assert property (@(posedge write_clock) disable iff (!arst_n)
		(rsp.ack || rsp.err) |-> ($past(req.cyc && req.stb) && !(rsp.ack && rsp.err)));

endmodule

// File: design/wb_pkg.sv
// Wishbone classic bus types for the FIFO bank ports.
// Both ports use the same request and response structs.
package wb_pkg;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [4:0]  adr; // bit 4 is the read space, 3:0 the channel.
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic        err;
		logic [15:0] dat;
	} wb_rsp_t;

	typedef enum logic {
		RD_DATA   = 1'b0,
		RD_STATUS = 1'b1
	} rd_space_e;

	typedef enum logic {IDLE, HOLD} wr_state_e;

endpackage

// File: fifo_centre.f
design/fbc_pkg.sv
design/wb_pkg.sv
design/fifo_wb_writer.sv
design/fifo_dc_16to8.sv
design/fifo_wb_reader.sv
design/fifo_centre.sv
verif/fifo_centre_tb.sv

// File: verif/fifo_centre_tb.sv
`timescale 1ns/1ps
// Testbench for the frame buffer FIFO bank.
// Drives both Wishbone ports, keeps one byte queue per channel as the
// reference and checks every read answer against it. Compile with fifo_centre.f.
module fifo_centre_tb
	import fbc_pkg::*, wb_pkg::*;
();
	localparam int DEPTH_LOG2 = 4;
	localparam int DEPTH      = 2**DEPTH_LOG2;
	localparam int TIMEOUT    = 200; // cycles allowed per bus access.

	typedef struct packed {
		logic       status;
		logic [3:0] chan;
		wb_rsp_t    rsp;
	} obs_t;

	logic        write_clock, read_clock, arst_n;
	wb_req_t     wr_req, rd_req;
	wb_rsp_t     wr_rsp, rd_rsp;
	byte_t       model [NUM_CHAN][$]; // expected bytes, head first.
	obs_t        obs_q [$];
	event        obs_ev;
	logic [31:0] rng = 32'd15536;
	int          checks, errors, tests, errors_before;
	logic        bp_done;

	fifo_centre #(.DEPTH_LOG2(DEPTH_LOG2)) fifo_centre_i (
		.write_clock (write_clock),
		.read_clock  (read_clock),
		.arst_n      (arst_n),
		.wr_req      (wr_req),
		.wr_rsp      (wr_rsp),
		.rd_req      (rd_req),
		.rd_rsp      (rd_rsp)
	);

	initial begin
		write_clock = 1'b0;
		forever #5 write_clock = ~write_clock;
	end

	initial begin
		read_clock = 1'b0;
		#3; // read domain runs offset.
		forever #5 read_clock = ~read_clock;
	end

	initial begin
		#200us;
		$display("simulation ran past its time limit");
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] xorshift();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic byte_t expect_byte(chan_e ch);
		return model[ch].pop_front();
	endfunction

	function automatic chan_status_t expect_status(chan_e ch);
		chan_status_t s;
		s.empty    = (model[ch].size() == 0);
		s.full     = (model[ch].size() == 2 * DEPTH);
		s.rd_count = 16'(model[ch].size());
		return s;
	endfunction

	task automatic check_byte(string what, byte_t got, byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s gave %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_status(string what, chan_status_t got, chan_status_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s full %b empty %b count %0d, expected %b %b %0d",
				$time, what, got.full, got.empty, got.rd_count, exp.full, exp.empty,
				exp.rd_count);
		end
	endtask

	task automatic check_resp(string what, wb_rsp_t got, logic exp_err);
		checks++;
		if (got.err !== exp_err || got.ack !== !exp_err) begin
			errors++;
			$display("mismatch at %0t: %s answered ack %b err %b, expected err %b",
				$time, what, got.ack, got.err, exp_err);
		end
	endtask

	task automatic wb_write(logic [3:0] adr, word_t dat, output wb_rsp_t rsp);
		int n;
		@(negedge write_clock);
		wr_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: {1'b0, adr}, dat: dat};
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge write_clock);
			if (wr_rsp.ack || wr_rsp.err) break;
		end
		rsp    = wr_rsp;
		wr_req = '0; // stb drops for at least one cycle.
		if (n == TIMEOUT) begin
			errors++;
			$display("write to channel %0d got no answer within %0d cycles", adr, TIMEOUT);
		end
	endtask

	task automatic wb_read(logic status, logic [3:0] adr);
		int n;
		@(negedge read_clock);
		rd_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: {status, adr}, dat: '0};
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge read_clock);
			if (rd_rsp.ack || rd_rsp.err) break;
		end
		rd_req = '0;
		if (n == TIMEOUT) begin
			errors++;
			$display("read from channel %0d got no answer within %0d cycles", adr, TIMEOUT);
		end else begin
			obs_q.push_back('{status: status, chan: adr, rsp: rd_rsp});
			-> obs_ev;
		end
	endtask

	task automatic compare_read(obs_t o);
		string what;
		what = $sformatf("%s read ch%0d", o.status ? "status" : "data", o.chan);
		if (o.chan > 4'(AT)) begin
			check_resp(what, o.rsp, 1'b1);
		end else if (o.status) begin
			check_resp(what, o.rsp, 1'b0);
			check_status(what, status_from_word(o.rsp.dat), expect_status(chan_e'(o.chan)));
		end else begin
			check_resp(what, o.rsp, model[o.chan].size() == 0);
			if (o.rsp.ack && model[o.chan].size() != 0)
				check_byte(what, byte_t'(o.rsp.dat), expect_byte(chan_e'(o.chan)));
		end
	endtask

	// every read answer is judged here against the model.
	always begin
		@(obs_ev);
		while (obs_q.size() > 0) compare_read(obs_q.pop_front());
	end

	task automatic write_word(logic [3:0] ch, word_t w);
		wb_rsp_t rsp;
		wb_write(ch, w, rsp);
		check_resp($sformatf("write ch%0d", ch), rsp, ch > 4'(AT));
		if (rsp.ack && ch <= 4'(AT)) begin
			model[ch].push_back(w[15:8]); // high byte leaves first.
			model[ch].push_back(w[7:0]);
		end
	endtask

	task automatic settle();
		repeat (6) @(posedge read_clock); // past both synchronizers.
	endtask

	task automatic end_test(string name);
		tests++;
		$display("test %s finished with %0d errors", name, errors - errors_before);
		errors_before = errors;
	endtask

	initial begin
		word_t w;
		chan_e ch;
		arst_n = 1'b0;
		wr_req = '0;
		rd_req = '0;
		checks = 0;
		errors = 0;
		tests = 0;
		errors_before = 0;
		bp_done = 1'b0;
		repeat (3) @(posedge write_clock);
		@(negedge write_clock);
		arst_n = 1'b1;

		for (int c = 0; c < NUM_CHAN; c++) begin
			repeat (3) write_word(4'(c), word_t'(xorshift()));
			settle();
			repeat (6) wb_read(1'b0, 4'(c));
		end
		settle();
		end_test("order");

		for (int i = 0; i < 4; i++) begin
			write_word(4'(DS2), word_t'(xorshift()));
			write_word(4'(DS5), word_t'(xorshift()));
			write_word(4'(AT), word_t'(xorshift()));
		end
		settle();
		repeat (8) wb_read(1'b0, 4'(DS2));
		repeat (8) wb_read(1'b0, 4'(DS5));
		repeat (8) wb_read(1'b0, 4'(AT));
		settle();
		end_test("isolation");

		wb_read(1'b0, 4'(DS3)); // empty channel.
		write_word(4'(DS3), 16'ha55a);
		settle();
		repeat (2) wb_read(1'b0, 4'(DS3));
		for (int c = 9; c < 16; c++) begin
			write_word(4'(c), 16'h1234);
			wb_read(1'b0, 4'(c));
			wb_read(1'b1, 4'(c));
		end
		settle();
		end_test("errors");

		for (int i = 0; i < DEPTH; i++) write_word(4'(DS0), word_t'(xorshift()));
		w = word_t'(xorshift());
		fork
			begin
				write_word(4'(DS0), w);
				bp_done = 1'b1;
			end
		join_none
		repeat (30) @(posedge write_clock);
		checks++;
		if (bp_done) begin
			errors++;
			$display("write to a full DS0 finished before any byte was read");
		end
		repeat (2) wb_read(1'b0, 4'(DS0));
		for (int n = 0; n < TIMEOUT && !bp_done; n++) @(posedge write_clock);
		if (!bp_done) begin
			errors++;
			$display("held write to DS0 never finished after bytes were read");
		end
		settle();
		repeat (2 * DEPTH) wb_read(1'b0, 4'(DS0));
		settle();
		end_test("back-pressure");

		for (int i = 0; i < DEPTH; i++) write_word(4'(DS7), word_t'(xorshift()));
		repeat (3) write_word(4'(DS6), word_t'(xorshift()));
		settle();
		wb_read(1'b0, 4'(DS6)); // leaves an odd byte count.
		settle();
		wb_read(1'b1, 4'(DS4));
		wb_read(1'b1, 4'(DS6));
		wb_read(1'b1, 4'(DS7));
		wb_read(1'b1, 4'(AT));
		settle();
		end_test("status");

		for (int i = 0; i < 200; i++) begin
			ch = chan_e'(xorshift() % NUM_CHAN);
			if ((xorshift() & 32'd1) != 0 && model[ch].size() <= 2 * DEPTH - 2) begin
				write_word(4'(ch), word_t'(xorshift()));
			end else begin
				settle();
				wb_read(1'b0, 4'(ch));
			end
		end
		settle();
		end_test("random");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
